// File: src/dsp_pkg.sv
// Shared widths, opcode codes and register codes of the DSP control core, referenced by scoped names
package dsp_pkg;

    typedef logic [15:0] word_t;      // Data or instruction word
    typedef logic [11:0] pc_t;        // Program address
    typedef logic [8:0]  short_imm_t;
    typedef logic [2:0]  reg_sel_t;
    typedef logic [1:0]  mod_t;       // Post-modify mode
    typedef logic [4:0]  t_field_t;   // Opcode field, word bits 15..11
    typedef logic [1:0]  acc_op_t;

    // Register select codes, Y unit below 6
    localparam reg_sel_t sel_r0 = 3'd0;
    localparam reg_sel_t sel_r1 = 3'd1;
    localparam reg_sel_t sel_r2 = 3'd2;
    localparam reg_sel_t sel_r3 = 3'd3;
    localparam reg_sel_t sel_j  = 3'd4;
    localparam reg_sel_t sel_k  = 3'd5;
    localparam reg_sel_t sel_a0 = 3'd6;
    localparam reg_sel_t sel_a1 = 3'd7;

    // Pointer post-modify
    localparam mod_t mod_none = 2'd0;
    localparam mod_t mod_inc  = 2'd1;
    localparam mod_t mod_dec  = 2'd2;
    localparam mod_t mod_addj = 2'd3;

    // Goto and short share bit 11 with their payload
    localparam t_field_t op_goto  = 5'b00000;
    localparam t_field_t op_short = 5'b00010;
    localparam t_field_t op_long  = 5'b01010;
    localparam t_field_t op_store = 5'b01100;
    localparam t_field_t op_load  = 5'b01111;
    localparam t_field_t op_acc   = 5'b00110;

    localparam acc_op_t acc_add   = 2'd0;
    localparam acc_op_t acc_sub   = 2'd1;
    localparam acc_op_t acc_copy  = 2'd2;
    localparam acc_op_t acc_clear = 2'd3;

    typedef enum logic [1:0] {
        fetch_run,   // Next sequential word
        fetch_hold,  // Present the same address again
        fetch_jump   // Take the goto target
    } fetch_state_t;

endpackage

// File: src/dsp_fetch.sv
// Program counter of the DSP core, drives the ROM address and follows goto and halt strobes
`timescale 1ns/1ns

module dsp_fetch (
    input  logic          clk,
    input  logic          rst,
    input  logic          cen,
    input  logic          goto_ja,
    input  dsp_pkg::pc_t  jump_target,
    input  logic          pc_halt,
    output dsp_pkg::pc_t  rom_addr
);

    dsp_pkg::pc_t          pc;
    dsp_pkg::fetch_state_t state;

    // Action for the coming step, goto has priority over a halt
    always_comb begin
        if (goto_ja) begin
            state = dsp_pkg::fetch_jump;
        end else if (pc_halt) begin
            state = dsp_pkg::fetch_hold;
        end else begin
            state = dsp_pkg::fetch_run;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
        end else if (cen) begin
            case (state)
                dsp_pkg::fetch_run:  pc <= pc + 12'd1;  // Wraps at the top of ROM
                dsp_pkg::fetch_hold: pc <= pc;
                dsp_pkg::fetch_jump: pc <= jump_target;
                default:             pc <= pc;
            endcase
        end
    end

    // ROM is combinational, the decoder samples its word at each step
    assign rom_addr = pc;

endmodule

// File: src/dsp_decode.sv
// Instruction decoder of the DSP core, turns each sampled ROM word into one step of strobes
`timescale 1ns/1ns

module dsp_decode (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cen,
    input  dsp_pkg::word_t       rom_dout,
    // Fetch control
    output logic                 goto_ja,
    output dsp_pkg::pc_t         jump_target,
    output logic                 pc_halt,
    // Short immediate
    output logic                 short_load,
    output dsp_pkg::short_imm_t  short_imm,
    output dsp_pkg::reg_sel_t    r_field,
    // Long immediate
    output logic                 imm_load,
    output dsp_pkg::reg_sel_t    imm_sel,
    output dsp_pkg::word_t       long_imm,
    // RAM access
    output logic                 ram_we,
    output logic                 ram_load,
    output logic                 post_load,
    output dsp_pkg::reg_sel_t    rsel,
    output logic [1:0]           y_field,
    output dsp_pkg::mod_t        inc_mode,
    // Accumulator operation
    output logic                 acc_en,
    output logic                 acc_dst,
    output dsp_pkg::acc_op_t     acc_op
);

    dsp_pkg::t_field_t op;
    logic              double;     // Next sampled word is not an instruction
    logic              long_pend;  // Next sampled word is a long immediate
    logic              is_goto;
    logic              is_short;

    assign op = rom_dout[15:11];

    // Bit 11 belongs to the target or the register code
    assign is_goto  = op[4:1] == dsp_pkg::op_goto[4:1];
    assign is_short = op[4:1] == dsp_pkg::op_short[4:1];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            goto_ja    <= 1'b0;
            pc_halt    <= 1'b0;
            short_load <= 1'b0;
            imm_load   <= 1'b0;
            ram_we     <= 1'b0;
            ram_load   <= 1'b0;
            post_load  <= 1'b0;
            acc_en     <= 1'b0;
            double     <= 1'b0;
            long_pend  <= 1'b0;
        end else if (cen) begin
            // Every strobe lasts a single step
            goto_ja    <= 1'b0;
            pc_halt    <= 1'b0;
            short_load <= 1'b0;
            ram_we     <= 1'b0;
            ram_load   <= 1'b0;
            post_load  <= 1'b0;
            acc_en     <= 1'b0;
            double     <= 1'b0;
            long_pend  <= 1'b0;
            imm_load   <= long_pend;  // Second word of a long load

            if (!double) begin
                if (is_goto) begin
                    goto_ja <= 1'b1;
                    double  <= 1'b1;  // Drop the word already fetched
                end else if (is_short) begin
                    short_load <= rom_dout[11:9] <= dsp_pkg::sel_k;
                end else begin
                    case (op)
                        dsp_pkg::op_long: begin
                            long_pend <= 1'b1;
                            double    <= 1'b1;
                        end
                        dsp_pkg::op_store, dsp_pkg::op_load: begin
                            ram_we    <= op == dsp_pkg::op_store;
                            ram_load  <= op == dsp_pkg::op_load;
                            post_load <= 1'b1;
                            pc_halt   <= 1'b1;  // Next word comes again
                            double    <= 1'b1;
                        end
                        dsp_pkg::op_acc: acc_en <= 1'b1;
                        default: ;  // No-op
                    endcase
                end
            end
        end
    end

    // Fields follow the sampled word, only valid alongside their strobe
    always_ff @(posedge clk) begin
        if (cen) begin
            short_imm <= rom_dout[8:0];
            r_field   <= rom_dout[11:9];
            rsel      <= rom_dout[10:8];
            y_field   <= rom_dout[3:2];
            inc_mode  <= rom_dout[1:0];
            acc_dst   <= rom_dout[10];
            acc_op    <= rom_dout[1:0];
            imm_sel   <= rsel;      // Destination from the first long word
            long_imm  <= rom_dout;
            if (!double && is_goto) begin
                jump_target <= rom_dout[11:0];  // Kept until the next goto
            end
        end
    end

endmodule

// File: src/dsp_yaau.sv
// Y address unit of the DSP core, holds r0-r3, j and k and forms the data RAM address
`timescale 1ns/1ns

module dsp_yaau (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cen,
    input  logic                 short_load,
    input  dsp_pkg::short_imm_t  short_imm,
    input  dsp_pkg::reg_sel_t    r_field,
    input  logic                 imm_load,
    input  dsp_pkg::reg_sel_t    imm_sel,
    input  dsp_pkg::word_t       long_imm,
    input  logic                 ram_load,
    input  logic                 post_load,
    input  dsp_pkg::reg_sel_t    rsel,
    input  logic [1:0]           y_field,
    input  dsp_pkg::mod_t        inc_mode,
    input  dsp_pkg::word_t       ram_rdata,
    output dsp_pkg::word_t       ram_addr,
    output dsp_pkg::word_t       y_rdata
);

    dsp_pkg::word_t    r [0:3];
    dsp_pkg::word_t    j;
    dsp_pkg::word_t    k;
    dsp_pkg::word_t    ptr_next;
    logic              wr_en;
    dsp_pkg::reg_sel_t wr_sel;
    dsp_pkg::word_t    wr_data;

    assign ram_addr = r[y_field];

    always_comb begin
        case (inc_mode)
            dsp_pkg::mod_none: ptr_next = ram_addr;
            dsp_pkg::mod_inc:  ptr_next = ram_addr + 16'd1;
            dsp_pkg::mod_dec:  ptr_next = ram_addr - 16'd1;
            default:           ptr_next = ram_addr + j;  // mod_addj
        endcase
    end

    // At most one load source is active in a step
    always_comb begin
        wr_en   = 1'b0;
        wr_sel  = r_field;
        wr_data = {7'd0, short_imm};
        if (short_load) begin
            wr_en = r_field <= dsp_pkg::sel_k;
        end else if (imm_load) begin
            wr_en   = imm_sel <= dsp_pkg::sel_k;
            wr_sel  = imm_sel;
            wr_data = long_imm;
        end else if (ram_load) begin
            wr_en   = rsel <= dsp_pkg::sel_k;
            wr_sel  = rsel;
            wr_data = ram_rdata;
        end
    end

    always_comb begin
        case (rsel)
            dsp_pkg::sel_r0: y_rdata = r[0];
            dsp_pkg::sel_r1: y_rdata = r[1];
            dsp_pkg::sel_r2: y_rdata = r[2];
            dsp_pkg::sel_r3: y_rdata = r[3];
            dsp_pkg::sel_j:  y_rdata = j;
            dsp_pkg::sel_k:  y_rdata = k;
            default:         y_rdata = '0;  // Accumulators live in the data unit
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 4; i++) begin
                r[i] <= '0;
            end
            j <= '0;
            k <= '0;
        end else if (cen) begin
            if (post_load) begin
                r[y_field] <= ptr_next;
            end
            // A load into the pointer itself overrides the post-modify
            if (wr_en) begin
                case (wr_sel)
                    dsp_pkg::sel_r0: r[0] <= wr_data;
                    dsp_pkg::sel_r1: r[1] <= wr_data;
                    dsp_pkg::sel_r2: r[2] <= wr_data;
                    dsp_pkg::sel_r3: r[3] <= wr_data;
                    dsp_pkg::sel_j:  j    <= wr_data;
                    dsp_pkg::sel_k:  k    <= wr_data;
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: src/dsp_dau.sv
// Data unit of the DSP core, holds a0 and a1 and supplies the store data for RAM writes
`timescale 1ns/1ns

module dsp_dau (
    input  logic               clk,
    input  logic               rst,
    input  logic               cen,
    input  logic               imm_load,
    input  dsp_pkg::reg_sel_t  imm_sel,
    input  dsp_pkg::word_t     long_imm,
    input  logic               ram_load,
    input  logic               ram_we_ctl,
    input  dsp_pkg::reg_sel_t  rsel,
    input  dsp_pkg::word_t     y_rdata,
    input  dsp_pkg::word_t     ram_rdata,
    input  logic               acc_en,
    input  logic               acc_dst,
    input  dsp_pkg::acc_op_t   acc_op,
    output dsp_pkg::word_t     ram_wdata,
    output logic               ram_we
);

    dsp_pkg::word_t a0;
    dsp_pkg::word_t a1;
    dsp_pkg::word_t acc_cur;  // Destination accumulator
    dsp_pkg::word_t acc_src;  // The other one
    dsp_pkg::word_t acc_res;

    assign acc_cur = acc_dst ? a1 : a0;
    assign acc_src = acc_dst ? a0 : a1;

    always_comb begin
        case (acc_op)
            dsp_pkg::acc_add:  acc_res = acc_cur + acc_src;  // Wraps at 16 bits
            dsp_pkg::acc_sub:  acc_res = acc_cur - acc_src;
            dsp_pkg::acc_copy: acc_res = acc_src;
            default:           acc_res = '0;                 // acc_clear
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            a0 <= '0;
            a1 <= '0;
        end else if (cen) begin
            if (imm_load && imm_sel == dsp_pkg::sel_a0) begin
                a0 <= long_imm;
            end else if (ram_load && rsel == dsp_pkg::sel_a0) begin
                a0 <= ram_rdata;
            end else if (acc_en && !acc_dst) begin
                a0 <= acc_res;
            end

            if (imm_load && imm_sel == dsp_pkg::sel_a1) begin
                a1 <= long_imm;
            end else if (ram_load && rsel == dsp_pkg::sel_a1) begin
                a1 <= ram_rdata;
            end else if (acc_en && acc_dst) begin
                a1 <= acc_res;
            end
        end
    end

    // Store data source
    always_comb begin
        case (rsel)
            dsp_pkg::sel_a0: ram_wdata = a0;
            dsp_pkg::sel_a1: ram_wdata = a1;
            default:         ram_wdata = y_rdata;
        endcase
    end

    // Write strobe stays aligned with the store data
    assign ram_we = ram_we_ctl;

endmodule

// File: src/dsp_core.sv
// Top level of the DSP control core, links fetch, decoder and both units to the ROM and RAM ports
`timescale 1ns/1ns

module dsp_core (
    input  logic            clk,
    input  logic            rst,
    input  logic            cen,
    output dsp_pkg::pc_t    rom_addr,
    input  dsp_pkg::word_t  rom_dout,
    output dsp_pkg::word_t  ram_addr,
    output dsp_pkg::word_t  ram_wdata,
    output logic            ram_we,
    input  dsp_pkg::word_t  ram_rdata
);

    logic                 goto_ja;
    dsp_pkg::pc_t         jump_target;
    logic                 pc_halt;
    logic                 short_load;
    dsp_pkg::short_imm_t  short_imm;
    dsp_pkg::reg_sel_t    r_field;
    logic                 imm_load;
    dsp_pkg::reg_sel_t    imm_sel;
    dsp_pkg::word_t       long_imm;
    logic                 ram_we_ctl;  // Decoder write strobe
    logic                 ram_load;
    logic                 post_load;
    dsp_pkg::reg_sel_t    rsel;
    logic [1:0]           y_field;
    dsp_pkg::mod_t        inc_mode;
    logic                 acc_en;
    logic                 acc_dst;
    dsp_pkg::acc_op_t     acc_op;
    dsp_pkg::word_t       y_rdata;

    dsp_fetch i_fetch (
        .clk(clk), .rst(rst), .cen(cen),
        .goto_ja(goto_ja), .jump_target(jump_target), .pc_halt(pc_halt),
        .rom_addr(rom_addr)
    );

    dsp_decode i_decode (
        .clk(clk), .rst(rst), .cen(cen), .rom_dout(rom_dout),
        .goto_ja(goto_ja), .jump_target(jump_target), .pc_halt(pc_halt),
        .short_load(short_load), .short_imm(short_imm), .r_field(r_field),
        .imm_load(imm_load), .imm_sel(imm_sel), .long_imm(long_imm),
        .ram_we(ram_we_ctl), .ram_load(ram_load), .post_load(post_load),
        .rsel(rsel), .y_field(y_field), .inc_mode(inc_mode),
        .acc_en(acc_en), .acc_dst(acc_dst), .acc_op(acc_op)
    );

    dsp_yaau i_yaau (
        .clk(clk), .rst(rst), .cen(cen),
        .short_load(short_load), .short_imm(short_imm), .r_field(r_field),
        .imm_load(imm_load), .imm_sel(imm_sel), .long_imm(long_imm),
        .ram_load(ram_load), .post_load(post_load), .rsel(rsel),
        .y_field(y_field), .inc_mode(inc_mode), .ram_rdata(ram_rdata),
        .ram_addr(ram_addr), .y_rdata(y_rdata)
    );

    dsp_dau i_dau (
        .clk(clk), .rst(rst), .cen(cen),
        .imm_load(imm_load), .imm_sel(imm_sel), .long_imm(long_imm),
        .ram_load(ram_load), .ram_we_ctl(ram_we_ctl), .rsel(rsel),
        .y_rdata(y_rdata), .ram_rdata(ram_rdata),
        .acc_en(acc_en), .acc_dst(acc_dst), .acc_op(acc_op),
        .ram_wdata(ram_wdata), .ram_we(ram_we)
    );

endmodule

// File: verif/dsp_core_assert.sv
// Assertions bound into the DSP core top level, checking reset state, stalls and goto timing
`timescale 1ns/1ns

module dsp_core_assert (
    input logic           clk,
    input logic           rst,
    input logic           cen,
    input dsp_pkg::pc_t   rom_addr,
    input dsp_pkg::word_t ram_addr,
    input dsp_pkg::word_t ram_wdata,
    input logic           ram_we,
    input logic           goto_ja,
    input dsp_pkg::pc_t   jump_target,
    input logic           pc_halt,
    input logic           imm_load,
    input logic           acc_en
);

    // No write pending right after reset
    reset_clears_we: assert property (@(posedge clk) rst |=> !ram_we)
        else $error("ram_we high in the cycle after reset");

    stall_holds: assert property (@(posedge clk) disable iff (rst)
        !cen |=> $stable(rom_addr) && $stable(ram_addr) && $stable(ram_wdata)
                 && $stable(ram_we) && $stable(goto_ja) && $stable(pc_halt)
                 && $stable(imm_load) && $stable(acc_en))
        else $error("core state changed on an edge with cen low");

    goto_lands: assert property (@(posedge clk) disable iff (rst)
        goto_ja && cen |=> rom_addr == jump_target)
        else $error("rom_addr differs from the goto target after the jump step");

endmodule

bind dsp_core dsp_core_assert i_dsp_core_assert (
    .clk(clk), .rst(rst), .cen(cen), .rom_addr(rom_addr),
    .ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_we(ram_we),
    .goto_ja(goto_ja), .jump_target(jump_target), .pc_halt(pc_halt),
    .imm_load(imm_load), .acc_en(acc_en)
);

// File: verif/dsp_tb.sv
// Testbench for the DSP control core, runs a fixed program from a ROM model and checks every RAM write
`timescale 1ns/1ns

module dsp_tb;

    localparam int             prog_len       = 28;
    localparam int             timeout_cycles = 8 * prog_len + 100;
    localparam dsp_pkg::word_t nop_word       = 16'hf800;  // Opcode 11111 decodes to nothing
    localparam dsp_pkg::word_t imm_a0         = 16'h6105;  // Would be a store if executed
    localparam dsp_pkg::word_t imm_j          = 16'h0003;  // Would be a goto if executed
    localparam dsp_pkg::word_t load_addr      = 16'h0030;  // Preloaded RAM word
    localparam dsp_pkg::word_t load_data      = 16'hf00d;

    logic           clk = 1'b0;
    logic           rst;
    logic           cen;
    dsp_pkg::pc_t   rom_addr;
    dsp_pkg::word_t rom_dout;
    dsp_pkg::word_t ram_addr;
    dsp_pkg::word_t ram_wdata;
    logic           ram_we;
    dsp_pkg::word_t ram_rdata;

    dsp_pkg::word_t rom [0:4095];
    dsp_pkg::word_t ram [0:63];
    int             cycles = 0;

    // Expected RAM writes in program order
    string          exp_name [$];
    dsp_pkg::word_t exp_addr [$];
    dsp_pkg::word_t exp_data [$];

    dsp_pkg::word_t prog_table [0:prog_len-1] = '{
        16'h1010, 16'h13ab,  // r0 = 0x010, r1 = 0x1ab
        16'h6100,            // Store r1 at r0
        16'h5600, imm_a0,    // Long a0
        16'h5400, imm_j,     // Long j
        16'h6600, 16'h6400,  // Store a0, store j at r0
        16'h1420,            // r2 = 0x020
        16'h6208, 16'h6209,  // Store r2 at r2, none then inc
        16'h620a, 16'h620b,  // Dec, add j
        16'h6208,
        16'h0012,            // Goto 18
        16'h6500, 16'h6600,  // Skipped stores
        16'h6101,            // Store r1 at r0, inc
        16'h1630,            // r3 = 0x030
        16'h7f0c,            // Load a1 from r3
        16'h3000,            // a0 = a0 + a1
        16'h6600, 16'h6701,  // Store a0, store a1 with inc
        16'h3401,            // a1 = a1 - a0
        16'h6700,
        16'h001a,            // Goto self, end of program
        nop_word
    };

    dsp_core i_dsp_core (
        .clk(clk), .rst(rst), .cen(cen),
        .rom_addr(rom_addr), .rom_dout(rom_dout),
        .ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_we(ram_we),
        .ram_rdata(ram_rdata)
    );

    always #5 clk = ~clk;

    assign rom_dout  = rom[rom_addr];
    assign ram_rdata = ram[ram_addr[5:0]];

    // A held strobe during a stall writes only once
    always @(posedge clk) begin
        if (ram_we && cen) begin
            ram[ram_addr[5:0]] <= ram_wdata;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Test failed");
            $fatal(1, "Timeout after %0d cycles, the expected writes did not all occur", cycles);
        end
    end

    task automatic expect_write(input string name, input dsp_pkg::word_t addr,
                                input dsp_pkg::word_t data);
        exp_name.push_back(name);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic check_value(input string name, input dsp_pkg::word_t expected,
                               input dsp_pkg::word_t actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "Wrong value in %s", name);
        end
    endtask

    // Falling edge, then a new random cen for the next rising edge
    task automatic next_cycle();
        @(negedge clk);
        cen = ($urandom % 4) != 0;
    endtask

    initial begin
        int             i;
        logic [5:0]     a6;
        dsp_pkg::word_t sum;
        dsp_pkg::word_t diff;
        logic           extra_write;

        void'($urandom(32'h923d_e506));
        rst = 1'b1;
        cen = 1'b0;
        extra_write = 1'b0;
        for (i = 0; i < 4096; i++) begin
            rom[12'(i)] = nop_word;
        end
        for (i = 0; i < prog_len; i++) begin
            rom[12'(i)] = prog_table[5'(i)];
        end
        for (i = 0; i < 64; i++) begin
            a6 = 6'(i);
            ram[a6] = {4'hc, a6, ~a6};  // Distinct word per address
        end
        ram[load_addr[5:0]] = load_data;

        sum  = imm_a0 + load_data;  // a0 += a1, modulo 2^16
        diff = load_data - sum;     // a1 -= a0
        expect_write("short_store", 16'h0010, 16'h01ab);
        expect_write("long_a0",     16'h0010, imm_a0);
        expect_write("long_j",      16'h0010, imm_j);
        expect_write("mod_none",    16'h0020, 16'h0020);
        expect_write("mod_inc",     16'h0020, 16'h0020);
        expect_write("mod_dec",     16'h0021, 16'h0021);
        expect_write("mod_addj",    16'h0020, 16'h0020);
        expect_write("after_addj",  16'h0020 + imm_j, 16'h0020 + imm_j);
        expect_write("goto_target", 16'h0010, 16'h01ab);
        expect_write("acc_add",     16'h0011, sum);
        expect_write("load_a1",     16'h0011, load_data);
        expect_write("acc_sub",     16'h0012, diff);

        repeat (2) @(negedge clk);
        rst = 1'b0;
        for (i = 0; i < exp_addr.size(); i++) begin
            do begin
                next_cycle();
            end while (!(ram_we && cen));  // Write commits on the coming edge
            check_value({exp_name[i], " address"}, exp_addr[i], ram_addr);
            check_value({exp_name[i], " data"}, exp_data[i], ram_wdata);
        end
        for (i = 0; i < 20 && !extra_write; i++) begin
            next_cycle();
            extra_write = ram_we && cen;
        end
        if (extra_write) begin
            $display("Unexpected RAM write to %h after the last expected write", ram_addr);
            $display("Test failed");
            $fatal(1, "Extra RAM write");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

// File: verilog.f
src/dsp_pkg.sv
src/dsp_fetch.sv
src/dsp_decode.sv
src/dsp_yaau.sv
src/dsp_dau.sv
src/dsp_core.sv
verif/dsp_core_assert.sv
verif/dsp_tb.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir &&
verilator --binary --assert --timescale 1ns/1ns -j 0 --top-module dsp_tb -f verilog.f -o dsp_sim &&
./obj_dir/dsp_sim ||
{ echo "Simulation did not pass"; exit 1; }
